// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_core
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: all.f
+incdir+include
rtl/isa_pkg.sv
rtl/core_pkg.sv
rtl/id_stage.sv
rtl/issue_stage.sv
rtl/ex_stage.sv
rtl/commit_stage.sv
rtl/perf_counters.sv
rtl/core_top.sv
verification/tb_core.sv

// File: rtl/commit_stage.sv
`timescale 1ns/1ps

module commit_stage #(
  parameter int unsigned CommitCredits = core_pkg::COMMIT_CREDITS_DEFAULT
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              head_valid_i,
  input  logic                              head_done_i,
  input  logic [isa_pkg::REG_ADDR_BITS-1:0] head_rd_i,
  input  logic [isa_pkg::XLEN-1:0]          head_result_i,
  input  logic                              head_ex_i,
  input  logic                              commit_credit_i,
  output logic                              commit_ack_o,
  // register file write port
  output logic                              we_o,
  output logic [isa_pkg::REG_ADDR_BITS-1:0] waddr_o,
  output logic [isa_pkg::XLEN-1:0]          wdata_o,
  // output edge
  output logic                              commit_valid_o,
  output logic [isa_pkg::REG_ADDR_BITS-1:0] commit_rd_o,
  output logic [isa_pkg::XLEN-1:0]          commit_data_o,
  output logic                              commit_ex_o
);

  localparam int unsigned CreditBits = $clog2(CommitCredits + 1);

  logic [CreditBits-1:0] credit_q;
  logic                  commit;

  // ------------------------------------------------------------
  // in-order commit under output credits
  // ------------------------------------------------------------
  assign commit       = head_valid_i & head_done_i & (credit_q != '0);
  assign commit_ack_o = commit;

  // exceptions and x0 leave the register file alone
  assign we_o    = commit & ~head_ex_i & (head_rd_i != '0);
  assign waddr_o = head_rd_i;
  assign wdata_o = head_result_i;

  assign commit_valid_o = commit;
  assign commit_rd_o    = head_rd_i;
  assign commit_data_o  = head_ex_i ? '0 : head_result_i;
  assign commit_ex_o    = head_ex_i;

  // one credit spent per commit, at most one returned per cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credit_q <= CreditBits'(CommitCredits);
    end else begin
      credit_q <= credit_q - CreditBits'(commit) + CreditBits'(commit_credit_i);
    end
  end

endmodule

// File: rtl/core_pkg.sv
package core_pkg;

  // ------------------------------------------------------------
  // default sizing of the core
  // ------------------------------------------------------------
  // instruction buffer slots, also the input credits after reset
  localparam int unsigned IQ_DEPTH_DEFAULT       = 4;
  // scoreboard entries, sets the transaction id width
  localparam int unsigned NR_SB_ENTRIES_DEFAULT  = 4;
  // output credits after reset
  localparam int unsigned COMMIT_CREDITS_DEFAULT = 2;

  // ------------------------------------------------------------
  // performance counters
  // ------------------------------------------------------------
  localparam int unsigned PERF_SEL_BITS = 2;
  localparam int unsigned PERF_CNT_BITS = 32;

endpackage

// File: rtl/core_top.sv
`timescale 1ns/1ps

module core_top #(
  parameter int unsigned IqDepth       = core_pkg::IQ_DEPTH_DEFAULT,
  parameter int unsigned NrSbEntries   = core_pkg::NR_SB_ENTRIES_DEFAULT,
  parameter int unsigned CommitCredits = core_pkg::COMMIT_CREDITS_DEFAULT
) (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               instr_valid_i,
  input  logic [31:0]                        instr_i,
  input  logic                               commit_credit_i,
  input  logic [core_pkg::PERF_SEL_BITS-1:0] perf_sel_i,
  output logic                               instr_credit_o,
  output logic                               commit_valid_o,
  output logic [isa_pkg::REG_ADDR_BITS-1:0]  commit_rd_o,
  output logic [isa_pkg::XLEN-1:0]           commit_data_o,
  output logic                               commit_ex_o,
  output logic [core_pkg::PERF_CNT_BITS-1:0] perf_data_o
);

  localparam int unsigned TransIdBits = $clog2(NrSbEntries);

  // decode to issue
  logic                              decoded_valid, issue_ack, dec_use_imm, dec_illegal;
  isa_pkg::alu_op_e                  dec_op;
  logic [isa_pkg::REG_ADDR_BITS-1:0] dec_rd, dec_rs1, dec_rs2;
  logic [isa_pkg::XLEN-1:0]          dec_imm;
  // issue to execute and writeback
  logic                              alu_valid, wb_valid;
  isa_pkg::alu_op_e                  alu_op;
  logic [isa_pkg::XLEN-1:0]          opa, opb, wb_result;
  logic [TransIdBits-1:0]            alu_trans_id, wb_trans_id;
  // scoreboard head and commit
  logic                              head_valid, head_done, head_ex, commit_ack, we, stall;
  logic [isa_pkg::REG_ADDR_BITS-1:0] head_rd, waddr;
  logic [isa_pkg::XLEN-1:0]          head_result, wdata;

  id_stage #(.IqDepth(IqDepth)) i_id_stage (
    .clk_i, .rst_ni, .instr_valid_i, .instr_i,
    .issue_ack_i(issue_ack), .instr_credit_o, .decoded_valid_o(decoded_valid),
    .op_o(dec_op), .rd_o(dec_rd), .rs1_o(dec_rs1), .rs2_o(dec_rs2),
    .use_imm_o(dec_use_imm), .imm_o(dec_imm), .illegal_o(dec_illegal)
  );

  issue_stage #(.NrSbEntries(NrSbEntries)) i_issue_stage (
    .clk_i, .rst_ni, .decoded_valid_i(decoded_valid), .op_i(dec_op), .rd_i(dec_rd),
    .rs1_i(dec_rs1), .rs2_i(dec_rs2), .use_imm_i(dec_use_imm), .imm_i(dec_imm),
    .illegal_i(dec_illegal), .wb_valid_i(wb_valid), .wb_trans_id_i(wb_trans_id),
    .wb_result_i(wb_result), .commit_ack_i(commit_ack), .we_i(we), .waddr_i(waddr),
    .wdata_i(wdata), .issue_ack_o(issue_ack), .alu_valid_o(alu_valid), .alu_op_o(alu_op),
    .opa_o(opa), .opb_o(opb), .trans_id_o(alu_trans_id), .head_valid_o(head_valid),
    .head_done_o(head_done), .head_rd_o(head_rd), .head_result_o(head_result),
    .head_ex_o(head_ex), .stall_o(stall)
  );

  ex_stage #(.NrSbEntries(NrSbEntries)) i_ex_stage (
    .clk_i, .rst_ni, .alu_valid_i(alu_valid), .alu_op_i(alu_op), .opa_i(opa),
    .opb_i(opb), .trans_id_i(alu_trans_id), .wb_valid_o(wb_valid),
    .wb_trans_id_o(wb_trans_id), .wb_result_o(wb_result)
  );

  commit_stage #(.CommitCredits(CommitCredits)) i_commit_stage (
    .clk_i, .rst_ni, .head_valid_i(head_valid), .head_done_i(head_done),
    .head_rd_i(head_rd), .head_result_i(head_result), .head_ex_i(head_ex),
    .commit_credit_i, .commit_ack_o(commit_ack), .we_o(we), .waddr_o(waddr),
    .wdata_o(wdata), .commit_valid_o, .commit_rd_o, .commit_data_o, .commit_ex_o
  );

  perf_counters i_perf_counters (
    .clk_i, .rst_ni, .commit_i(commit_valid_o), .commit_ex_i(commit_ex_o),
    .stall_i(stall), .perf_sel_i, .perf_data_o
  );

endmodule

// File: rtl/ex_stage.sv
`timescale 1ns/1ps

module ex_stage #(
  parameter int unsigned NrSbEntries = core_pkg::NR_SB_ENTRIES_DEFAULT,
  localparam int unsigned TransIdBits = $clog2(NrSbEntries)
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     alu_valid_i,
  input  isa_pkg::alu_op_e         alu_op_i,
  input  logic [isa_pkg::XLEN-1:0] opa_i,
  input  logic [isa_pkg::XLEN-1:0] opb_i,
  input  logic [TransIdBits-1:0]   trans_id_i,
  output logic                     wb_valid_o,
  output logic [TransIdBits-1:0]   wb_trans_id_o,
  output logic [isa_pkg::XLEN-1:0] wb_result_o
);

  logic [isa_pkg::XLEN-1:0] alu_res;

  always_comb begin
    case (alu_op_i)
      isa_pkg::ADD: alu_res = opa_i + opb_i;
      isa_pkg::SUB: alu_res = opa_i - opb_i;
      isa_pkg::AND: alu_res = opa_i & opb_i;
      isa_pkg::OR:  alu_res = opa_i | opb_i;
      isa_pkg::XOR: alu_res = opa_i ^ opb_i;
      // shift amount from the low 5 bits
      isa_pkg::SLL: alu_res = opa_i << opb_i[4:0];
      isa_pkg::SRL: alu_res = opa_i >> opb_i[4:0];
      isa_pkg::SLT: alu_res = {{(isa_pkg::XLEN - 1){1'b0}}, $signed(opa_i) < $signed(opb_i)};
      default:      alu_res = '0;
    endcase
  end

  // one cycle to writeback
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wb_valid_o <= 1'b0;
    end else begin
      wb_valid_o <= alu_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (alu_valid_i) begin
      wb_result_o   <= alu_res;
      wb_trans_id_o <= trans_id_i;
    end
  end

endmodule

// File: rtl/id_stage.sv
`timescale 1ns/1ps

module id_stage #(
  parameter int unsigned IqDepth = core_pkg::IQ_DEPTH_DEFAULT
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  instr_valid_i,
  input  logic [31:0]                           instr_i,
  input  logic                                  issue_ack_i,
  output logic                                  instr_credit_o,
  output logic                                  decoded_valid_o,
  output isa_pkg::alu_op_e                      op_o,
  output logic [isa_pkg::REG_ADDR_BITS-1:0]     rd_o,
  output logic [isa_pkg::REG_ADDR_BITS-1:0]     rs1_o,
  output logic [isa_pkg::REG_ADDR_BITS-1:0]     rs2_o,
  output logic                                  use_imm_o,
  output logic [isa_pkg::XLEN-1:0]              imm_o,
  output logic                                  illegal_o
);

  localparam int unsigned PtrBits = $clog2(IqDepth);
  localparam int unsigned CntBits = $clog2(IqDepth + 1);

  logic [31:0]        mem_q [IqDepth];
  logic [PtrBits-1:0] rd_ptr_q, wr_ptr_q;
  logic [CntBits-1:0] cnt_q;
  logic               pop;
  isa_pkg::instr_u    head;

  // ------------------------------------------------------------
  // instruction buffer
  // ------------------------------------------------------------
  // the sender holds a credit for every word, so no full check
  assign pop             = decoded_valid_o & issue_ack_i;
  assign instr_credit_o  = pop;
  assign decoded_valid_o = (cnt_q != '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (instr_valid_i) begin
        wr_ptr_q <= (wr_ptr_q == PtrBits'(IqDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrBits'(IqDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      cnt_q <= cnt_q + CntBits'(instr_valid_i) - CntBits'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (instr_valid_i) begin
      mem_q[wr_ptr_q] <= instr_i;
    end
  end

  // ------------------------------------------------------------
  // decode of the buffer head
  // ------------------------------------------------------------
  assign head      = mem_q[rd_ptr_q];
  assign op_o      = isa_pkg::alu_op_e'(head.r.op);
  assign illegal_o = head.r.op[3];
  assign use_imm_o = head.i.fmt;
  assign rd_o      = head.r.rd;
  assign rs1_o     = head.r.rs1;
  // no second source in the I view, x0 never causes a hazard
  assign rs2_o     = head.i.fmt ? '0 : head.r.rs2;
  assign imm_o     = {{(isa_pkg::XLEN - 17){head.i.imm[16]}}, head.i.imm};

endmodule

// File: rtl/isa_pkg.sv
package isa_pkg;

  // ------------------------------------------------------------
  // datapath sizes
  // ------------------------------------------------------------
  localparam int unsigned XLEN          = 32;
  localparam int unsigned NR_REGS       = 32;
  localparam int unsigned REG_ADDR_BITS = 5;

  // ------------------------------------------------------------
  // operation codes
  // ------------------------------------------------------------
  // codes 8 to 15 are not defined and decode as illegal
  typedef enum logic [3:0] {
    ADD = 4'd0,
    SUB = 4'd1,
    AND = 4'd2,
    OR  = 4'd3,
    XOR = 4'd4,
    SLL = 4'd5,
    SRL = 4'd6,
    SLT = 4'd7
  } alu_op_e;

  // ------------------------------------------------------------
  // instruction word formats
  // ------------------------------------------------------------
  // register-register, fmt is 0
  typedef struct packed {
    logic [3:0]               op;
    logic                     fmt;
    logic [REG_ADDR_BITS-1:0] rd;
    logic [REG_ADDR_BITS-1:0] rs1;
    logic [REG_ADDR_BITS-1:0] rs2;
    logic [11:0]              unused;
  } instr_r_t;

  // register-immediate, fmt is 1
  typedef struct packed {
    logic [3:0]               op;
    logic                     fmt;
    logic [REG_ADDR_BITS-1:0] rd;
    logic [REG_ADDR_BITS-1:0] rs1;
    logic signed [16:0]       imm;
  } instr_i_t;

  // bit 27 picks the view
  typedef union packed {
    instr_r_t r;
    instr_i_t i;
  } instr_u;

endpackage

// File: rtl/issue_stage.sv
`timescale 1ns/1ps

module issue_stage #(
  parameter int unsigned NrSbEntries = core_pkg::NR_SB_ENTRIES_DEFAULT,
  localparam int unsigned TransIdBits = $clog2(NrSbEntries)
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  // from decode
  input  logic                              decoded_valid_i,
  input  isa_pkg::alu_op_e                  op_i,
  input  logic [isa_pkg::REG_ADDR_BITS-1:0] rd_i,
  input  logic [isa_pkg::REG_ADDR_BITS-1:0] rs1_i,
  input  logic [isa_pkg::REG_ADDR_BITS-1:0] rs2_i,
  input  logic                              use_imm_i,
  input  logic [isa_pkg::XLEN-1:0]          imm_i,
  input  logic                              illegal_i,
  // writeback from execute
  input  logic                              wb_valid_i,
  input  logic [TransIdBits-1:0]            wb_trans_id_i,
  input  logic [isa_pkg::XLEN-1:0]          wb_result_i,
  // from commit
  input  logic                              commit_ack_i,
  input  logic                              we_i,
  input  logic [isa_pkg::REG_ADDR_BITS-1:0] waddr_i,
  input  logic [isa_pkg::XLEN-1:0]          wdata_i,
  output logic                              issue_ack_o,
  // to execute
  output logic                              alu_valid_o,
  output isa_pkg::alu_op_e                  alu_op_o,
  output logic [isa_pkg::XLEN-1:0]          opa_o,
  output logic [isa_pkg::XLEN-1:0]          opb_o,
  output logic [TransIdBits-1:0]            trans_id_o,
  // scoreboard head
  output logic                              head_valid_o,
  output logic                              head_done_o,
  output logic [isa_pkg::REG_ADDR_BITS-1:0] head_rd_o,
  output logic [isa_pkg::XLEN-1:0]          head_result_o,
  output logic                              head_ex_o,
  output logic                              stall_o
);

  localparam int unsigned CntBits = $clog2(NrSbEntries + 1);

  logic [NrSbEntries-1:0]            sb_valid_q, sb_done_q, sb_ex_q;
  logic [isa_pkg::REG_ADDR_BITS-1:0] sb_rd_q     [NrSbEntries];
  logic [isa_pkg::XLEN-1:0]          sb_result_q [NrSbEntries];
  logic [TransIdBits-1:0]            head_q, tail_q;
  logic [CntBits-1:0]                cnt_q;
  logic [isa_pkg::XLEN-1:0]          rf_q [isa_pkg::NR_REGS];
  logic [isa_pkg::XLEN-1:0]          rs1_data, rs2_data;
  logic                              full, hazard;

  // ------------------------------------------------------------
  // hazard check and issue
  // ------------------------------------------------------------
  // any uncommitted producer of a source blocks, no forwarding
  always_comb begin
    hazard = 1'b0;
    for (int i = 0; i < NrSbEntries; i++) begin
      if (sb_valid_q[i] && !sb_ex_q[i] && (sb_rd_q[i] != '0)) begin
        if ((sb_rd_q[i] == rs1_i) || (sb_rd_q[i] == rs2_i)) begin
          hazard = 1'b1;
        end
      end
    end
  end

  assign full        = (cnt_q == CntBits'(NrSbEntries));
  assign issue_ack_o = decoded_valid_i & ~full & ~hazard;
  assign stall_o     = decoded_valid_i & (full | hazard);

  // x0 reads as zero
  assign rs1_data = (rs1_i == '0) ? '0 : rf_q[rs1_i];
  assign rs2_data = (rs2_i == '0) ? '0 : rf_q[rs2_i];

  // illegal ops never reach execute
  assign alu_valid_o = issue_ack_o & ~illegal_i;
  assign alu_op_o    = op_i;
  assign opa_o       = rs1_data;
  assign opb_o       = use_imm_i ? imm_i : rs2_data;
  assign trans_id_o  = tail_q;

  assign head_valid_o  = sb_valid_q[head_q];
  assign head_done_o   = sb_done_q[head_q];
  assign head_ex_o     = sb_ex_q[head_q];
  assign head_rd_o     = sb_rd_q[head_q];
  assign head_result_o = sb_result_q[head_q];

  // ------------------------------------------------------------
  // scoreboard and register file
  // ------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sb_valid_q <= '0;
      sb_done_q  <= '0;
      sb_ex_q    <= '0;
      head_q     <= '0;
      tail_q     <= '0;
      cnt_q      <= '0;
      for (int r = 0; r < isa_pkg::NR_REGS; r++) begin
        rf_q[r] <= '0;
      end
    end else begin
      if (issue_ack_o) begin
        sb_valid_q[tail_q] <= 1'b1;
        sb_done_q[tail_q]  <= illegal_i;
        sb_ex_q[tail_q]    <= illegal_i;
        tail_q <= (tail_q == TransIdBits'(NrSbEntries - 1)) ? '0 : tail_q + 1'b1;
      end
      if (wb_valid_i) begin
        sb_done_q[wb_trans_id_i] <= 1'b1;
      end
      if (commit_ack_i) begin
        sb_valid_q[head_q] <= 1'b0;
        head_q <= (head_q == TransIdBits'(NrSbEntries - 1)) ? '0 : head_q + 1'b1;
      end
      cnt_q <= cnt_q + CntBits'(issue_ack_o) - CntBits'(commit_ack_i);
      if (we_i) begin
        rf_q[waddr_i] <= wdata_i;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue_ack_o) begin
      sb_rd_q[tail_q]     <= rd_i;
      sb_result_q[tail_q] <= '0;
    end
    if (wb_valid_i) begin
      sb_result_q[wb_trans_id_i] <= wb_result_i;
    end
  end

endmodule

// File: rtl/perf_counters.sv
`timescale 1ns/1ps

module perf_counters (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               commit_i,
  input  logic                               commit_ex_i,
  input  logic                               stall_i,
  input  logic [core_pkg::PERF_SEL_BITS-1:0] perf_sel_i,
  output logic [core_pkg::PERF_CNT_BITS-1:0] perf_data_o
);

  localparam int unsigned NrCounters = 2 ** core_pkg::PERF_SEL_BITS;

  logic [core_pkg::PERF_CNT_BITS-1:0] cnt_q [NrCounters];

  // 0 legal commits, 1 exceptions, 2 stall cycles, 3 cycles
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NrCounters; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      if (commit_i && !commit_ex_i) begin
        cnt_q[0] <= cnt_q[0] + 1'b1;
      end
      if (commit_i && commit_ex_i) begin
        cnt_q[1] <= cnt_q[1] + 1'b1;
      end
      if (stall_i) begin
        cnt_q[2] <= cnt_q[2] + 1'b1;
      end
      cnt_q[3] <= cnt_q[3] + 1'b1;
    end
  end

  assign perf_data_o = cnt_q[perf_sel_i];

endmodule

// File: include/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// reference register file, x0 is never written
logic [31:0] ref_rf [32];
// expected commits in send order, packed as {ex, rd, data}
logic [37:0] exp_q [$];
string       exp_tag_q [$];
int          n_legal = 0;
int          n_illegal = 0;

function automatic logic [31:0] build_r(input logic [3:0] op, input logic [4:0] rd,
                                        input logic [4:0] rs1, input logic [4:0] rs2);
  isa_pkg::instr_u w;
  w.r.op     = op;
  w.r.fmt    = 1'b0;
  w.r.rd     = rd;
  w.r.rs1    = rs1;
  w.r.rs2    = rs2;
  w.r.unused = '0;
  return w;
endfunction

function automatic logic [31:0] build_i(input logic [3:0] op, input logic [4:0] rd,
                                        input logic [4:0] rs1, input logic [16:0] imm);
  isa_pkg::instr_u w;
  w.i.op  = op;
  w.i.fmt = 1'b1;
  w.i.rd  = rd;
  w.i.rs1 = rs1;
  w.i.imm = imm;
  return w;
endfunction

function automatic logic [31:0] alu_ref(input logic [3:0] op, input logic [31:0] a,
                                        input logic [31:0] b);
  case (op)
    4'd0:    return a + b;
    4'd1:    return a - b;
    4'd2:    return a & b;
    4'd3:    return a | b;
    4'd4:    return a ^ b;
    4'd5:    return a << b[4:0];
    4'd6:    return a >> b[4:0];
    4'd7:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    default: return 32'd0;
  endcase
endfunction

// called in send order, so the queue matches commit order
task automatic model_instr(input logic [31:0] word, input string tag);
  logic [4:0]  rd;
  logic [31:0] b;
  logic [31:0] res;
  rd = word[26:22];
  b  = word[27] ? {{15{word[16]}}, word[16:0]} : ref_rf[word[16:12]];
  if (word[31]) begin
    exp_q.push_back({1'b1, rd, 32'h0});
    n_illegal++;
  end else begin
    res = alu_ref(word[31:28], ref_rf[word[21:17]], b);
    if (rd != 5'd0) begin
      ref_rf[rd] = res;
    end
    exp_q.push_back({1'b0, rd, res});
    n_legal++;
  end
  exp_tag_q.push_back(tag);
endtask

`endif

// File: verification/tb_core.sv
`timescale 1ns/1ps

module tb_core;

  logic        clk_i;
  logic        rst_ni;
  logic        instr_valid_i;
  logic [31:0] instr_i;
  logic        commit_credit_i;
  logic [1:0]  perf_sel_i;
  logic        instr_credit_o;
  logic        commit_valid_o;
  logic [4:0]  commit_rd_o;
  logic [31:0] commit_data_o;
  logic        commit_ex_o;
  logic [31:0] perf_data_o;

  `include "tb_ref_model.svh"

  logic [31:0] prog [$];
  string       prog_tag [$];
  int          n_prog = 0;
  int          words_sent = 0;
  int          in_pulses = 0;
  int          commits_seen = 0;
  int          credits_given = 0;
  // expectation for the commit in the current cycle
  logic        exp_present = 1'b1;
  logic        exp_ex;
  logic [4:0]  exp_rd;
  logic [31:0] exp_data;
  string       exp_test = "none";
  // counter check mode 1 means equal and mode 2 means at least
  logic [1:0]  perf_mode = 2'd0;
  logic [31:0] perf_exp = '0;
  string       perf_test = "none";

  core_top #(
    .IqDepth      (core_pkg::IQ_DEPTH_DEFAULT),
    .NrSbEntries  (core_pkg::NR_SB_ENTRIES_DEFAULT),
    .CommitCredits(core_pkg::COMMIT_CREDITS_DEFAULT)
  ) uut (
    .clk_i, .rst_ni, .instr_valid_i, .instr_i, .commit_credit_i, .perf_sel_i,
    .instr_credit_o, .commit_valid_o, .commit_rd_o, .commit_data_o, .commit_ex_o,
    .perf_data_o
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("=== FAIL ===");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic report_mismatch(input string test, input string what,
                                 input logic [31:0] expected, input logic [31:0] actual);
    fail_run($sformatf("mismatch %s %s: expected %h, actual %h", test, what, expected, actual));
  endtask

  // ----------------------------------------------------------
  // checks
  // ----------------------------------------------------------
  a_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    commit_valid_o |-> exp_present)
    else fail_run("a commit arrived with no instruction outstanding");
  a_rd: assert property (@(posedge clk_i) disable iff (!rst_ni)
    commit_valid_o |-> (commit_rd_o == exp_rd))
    else report_mismatch(exp_test, "commit_rd", 32'(exp_rd), 32'($sampled(commit_rd_o)));
  a_data: assert property (@(posedge clk_i) disable iff (!rst_ni)
    commit_valid_o |-> (commit_data_o == exp_data))
    else report_mismatch(exp_test, "commit_data", exp_data, $sampled(commit_data_o));
  a_ex: assert property (@(posedge clk_i) disable iff (!rst_ni)
    commit_valid_o |-> (commit_ex_o == exp_ex))
    else report_mismatch(exp_test, "commit_ex", 32'(exp_ex), 32'($sampled(commit_ex_o)));
  a_out_credits: assert property (@(posedge clk_i) disable iff (!rst_ni)
    commits_seen <= credits_given + int'(core_pkg::COMMIT_CREDITS_DEFAULT))
    else fail_run("more commits were sent than output credits allow");
  a_in_credits: assert property (@(posedge clk_i) disable iff (!rst_ni)
    in_pulses <= words_sent)
    else fail_run("more input credits came back than words were sent");
  a_perf_eq: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (perf_mode == 2'd1) |-> (perf_data_o == perf_exp))
    else report_mismatch(perf_test, "perf_data", perf_exp, $sampled(perf_data_o));
  a_perf_ge: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (perf_mode == 2'd2) |-> (perf_data_o >= perf_exp))
    else report_mismatch(perf_test, "perf_data at least", perf_exp, $sampled(perf_data_o));

  // outputs are settled by the falling edge
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (instr_credit_o) begin
        in_pulses++;
      end
      if (commit_valid_o) begin
        commits_seen++;
        exp_present = (exp_q.size() != 0);
        if (exp_present) begin
          {exp_ex, exp_rd, exp_data} = exp_q.pop_front();
          exp_test = exp_tag_q.pop_front();
        end
      end
    end
  end

  task automatic add_word(input logic [31:0] word, input string tag);
    prog.push_back(word);
    prog_tag.push_back(tag);
  endtask

  task automatic build_program();
    logic [3:0] op;
    logic [4:0] rd;
    logic [4:0] prev;
    // small register set so random ops often depend on each other
    for (int k = 0; k < 40; k++) begin
      op = 4'($urandom_range(0, 7));
      rd = 5'($urandom_range(0, 7));
      if ($urandom_range(0, 1) == 1) begin
        add_word(build_i(op, rd, 5'($urandom_range(0, 7)), 17'($urandom)), "random_alu");
      end else begin
        add_word(build_r(op, rd, 5'($urandom_range(0, 7)), 5'($urandom_range(0, 7))),
                 "random_alu");
      end
    end
    prev = 5'd1;
    for (int k = 0; k < 12; k++) begin
      rd = 5'(8 + k % 4);
      if (k % 2 == 0) begin
        add_word(build_i(4'(k % 8), rd, prev, 17'(k * 3 + 1)), "dependent_chain");
      end else begin
        add_word(build_r(4'(k % 8), rd, prev, prev), "dependent_chain");
      end
      prev = rd;
    end
    add_word(build_i(4'd0, 5'd0, 5'd1, 17'h00123), "x0_write");
    add_word(build_r(4'd3, 5'd9, 5'd0, 5'd0), "x0_read");
    add_word(build_i(4'd0, 5'd10, 5'd0, 17'h1ffff), "x0_read");
    add_word(build_r(4'd1, 5'd0, 5'd2, 5'd3), "x0_write");
    add_word(build_r(4'd0, 5'd11, 5'd0, 5'd2), "x0_read");
    // each illegal op is followed by a read of its rd
    for (int k = 0; k < 6; k++) begin
      add_word(build_r(4'(8 + k), 5'(1 + k), 5'd2, 5'd3), "illegal_op");
      add_word(build_r(4'd0, 5'd12, 5'(1 + k), 5'd0), "after_illegal");
    end
  endtask

  // ----------------------------------------------------------
  // stimulus
  // ----------------------------------------------------------
  initial begin : stimulus
    int   cyc;
    int   avail;
    logic hold;
    rst_ni          = 1'b0;
    instr_valid_i   = 1'b0;
    instr_i         = '0;
    commit_credit_i = 1'b0;
    perf_sel_i      = '0;
    void'($urandom(32'hf927fcf8));
    foreach (ref_rf[r]) begin
      ref_rf[r] = '0;
    end
    build_program();
    n_prog = prog.size();
    repeat (3) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    cyc = 0;
    while (commits_seen < n_prog) begin
      @(posedge clk_i);
      #1;
      cyc++;
      // output credits held back for a while so the scoreboard fills
      hold  = (cyc >= 40) && (cyc < 90);
      avail = int'(core_pkg::IQ_DEPTH_DEFAULT) + in_pulses - words_sent;
      if ((words_sent < n_prog) && (avail > 0) && ($urandom_range(0, 4) != 0)) begin
        instr_valid_i = 1'b1;
        instr_i       = prog[words_sent];
        model_instr(prog[words_sent], prog_tag[words_sent]);
        words_sent++;
      end else begin
        instr_valid_i = 1'b0;
      end
      if (!hold && (commits_seen > credits_given) && ($urandom_range(0, 3) != 0)) begin
        commit_credit_i = 1'b1;
        credits_given++;
      end else begin
        commit_credit_i = 1'b0;
      end
    end
    @(posedge clk_i);
    #1;
    instr_valid_i   = 1'b0;
    commit_credit_i = 1'b0;
    perf_sel_i      = 2'd0;
    perf_exp        = 32'(n_legal);
    perf_test       = "perf_legal_commits";
    perf_mode       = 2'd1;
    @(posedge clk_i);
    #1;
    perf_sel_i = 2'd1;
    perf_exp   = 32'(n_illegal);
    perf_test  = "perf_exceptions";
    @(posedge clk_i);
    #1;
    // withheld output credits fill the scoreboard and stall issue
    perf_sel_i = 2'd2;
    perf_exp   = 32'd1;
    perf_test  = "perf_stall_cycles";
    perf_mode  = 2'd2;
    @(posedge clk_i);
    #1;
    perf_sel_i = 2'd3;
    perf_exp   = 32'(n_legal + n_illegal);
    perf_test  = "perf_cycles";
    @(posedge clk_i);
    #1;
    perf_mode = 2'd0;
    @(posedge clk_i);
    #1;
    $display("=== PASS ===");
    $finish;
  end

  initial begin : watchdog
    wait (n_prog != 0);
    repeat (200 * n_prog + 1000) @(posedge clk_i);
    fail_run("watchdog expired before all instructions committed");
  end

endmodule
